//--- hdl/timer_pkg.sv
//****************************************************************************
// Shared widths, constants and types for the timer host and its trigger path
// Referenced by scoped name from every RTL block and the testbench
//****************************************************************************

package timer_pkg;

    // Counter width and the vector type for counts, loads and compares
    localparam int timer_width = 16;
    typedef logic [timer_width-1:0] timer_t;

    // Observation stream byte
    typedef logic [7:0] obs_byte_t;

    // Clocks per timer tick while active
    localparam int prescaler = 4;
    typedef logic [1:0] prescale_t;

    // Stream generator, taps at 31, 27, 15 and 2
    typedef logic [31:0] lfsr_t;
    localparam lfsr_t lfsr_seed = 32'hCAFEBABE;

    // Documented trigger: this byte seen trigger_count times
    localparam obs_byte_t trigger_byte = 8'h3C;
    localparam int trigger_count = 8;
    typedef logic [3:0] trig_count_t;   // Holds 0 .. trigger_count

    // Timer control FSM
    typedef enum logic [1:0] {
        st_idle,
        st_running,
        st_overflow,
        st_match
    } timer_state_e;

    // Status bundle seen at the top level
    typedef struct packed {
        timer_t count;      // Counter, one register stage late
        logic   overflow;   // One-cycle pulse
        logic   match;      // One-cycle pulse
        logic   active;
    } timer_status_t;

endpackage

//--- hdl/byte_source.sv
//****************************************************************************
// Observation byte stream, LFSR bytes mixed with timer count and compare
//****************************************************************************
`timescale 1ns/1ps

module byte_source (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 advance,
    input  timer_pkg::timer_t    count,
    input  timer_pkg::timer_t    compare_value,
    output timer_pkg::obs_byte_t obs_byte
);

    timer_pkg::lfsr_t lfsr;
    logic [2:0]       sel;      // Which byte goes out this cycle
    logic             feedback;

    assign feedback = lfsr[31] ^ lfsr[27] ^ lfsr[15] ^ lfsr[2];

    // Shift and step the selector together
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= timer_pkg::lfsr_seed;
            sel  <= 3'd0;
        end else if (advance) begin
            lfsr <= {lfsr[30:0], feedback};     // New bit enters at the bottom
            sel  <= sel + 3'd1;
        end
    end

    // Count and compare halves for the mixed slots
    timer_pkg::obs_byte_t count_lo;
    timer_pkg::obs_byte_t count_hi;
    timer_pkg::obs_byte_t cmp_lo;
    timer_pkg::obs_byte_t cmp_hi;

    assign count_lo = count[7:0];
    assign count_hi = count[timer_pkg::timer_width-1 -: 8];
    assign cmp_lo   = compare_value[7:0];
    assign cmp_hi   = compare_value[timer_pkg::timer_width-1 -: 8];

    // Live compare_value reaches the stream without a register
    always_comb begin
        case (sel)
            3'd0:    obs_byte = lfsr[7:0];
            3'd1:    obs_byte = lfsr[15:8];
            3'd2:    obs_byte = lfsr[23:16];
            3'd3:    obs_byte = lfsr[31:24];
            3'd4:    obs_byte = lfsr[7:0] ^ count_lo;
            3'd5:    obs_byte = lfsr[15:8] ^ count_hi;
            3'd6:    obs_byte = lfsr[23:16] ^ cmp_lo;
            default: obs_byte = lfsr[31:24] ^ cmp_hi;   // Slot 7
        endcase
    end

endmodule

//--- hdl/trigger_detector.sv
//****************************************************************************
// Documented trigger path, counts trigger bytes and fires a one-clock clear
//****************************************************************************
`timescale 1ns/1ps

module trigger_detector (
    input  logic                 clk,
    input  logic                 rst,
    input  timer_pkg::obs_byte_t obs_byte,
    output logic                 tamper_reset
);

    logic                   hit;
    timer_pkg::trig_count_t hit_count;
    logic                   last_hit;

    assign hit = (obs_byte == timer_pkg::trigger_byte);

    // Threshold reached with this byte
    assign last_hit = hit &&
        (hit_count == timer_pkg::trig_count_t'(timer_pkg::trigger_count - 1));

    // Byte is sampled each edge, pulse lands one clock after the last hit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit_count    <= '0;
            tamper_reset <= 1'b0;
        end else begin
            tamper_reset <= last_hit;
            if (last_hit) begin
                hit_count <= '0;                // Start over after firing
            end else if (hit) begin
                hit_count <= hit_count + 1'b1;
            end
        end
    end

    // Gaps between trigger bytes do not reset the evidence count
    // Only rst or a completed threshold clears it

endmodule

//--- hdl/timer_core.sv
//****************************************************************************
// Up-counting timer with prescaler, compare match and overflow flags
// A tamper_reset pulse clears the whole core on the next edge
//****************************************************************************
`timescale 1ns/1ps

module timer_core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     tamper_reset,
    input  logic                     timer_enable,
    input  logic                     timer_reset,
    input  timer_pkg::timer_t        timer_load,
    input  timer_pkg::timer_t        compare_value,
    output timer_pkg::timer_status_t status
);

    timer_pkg::timer_state_e state;
    timer_pkg::timer_t       counter;
    timer_pkg::prescale_t    prescale_cnt;
    logic                    en_q;          // Enable from last cycle
    logic                    enable_rise;
    logic                    tick;
    logic                    keep_running;

    localparam timer_pkg::prescale_t prescale_last =
        timer_pkg::prescale_t'(timer_pkg::prescaler - 1);

    assign enable_rise  = timer_enable && !en_q;
    assign tick         = status.active && (prescale_cnt == prescale_last);
    assign keep_running = timer_enable && !timer_reset;

    // Prescaler runs only while active, so each run starts aligned
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prescale_cnt <= '0;
        end else if (tamper_reset || !status.active) begin
            prescale_cnt <= '0;
        end else if (prescale_cnt == prescale_last) begin
            prescale_cnt <= '0;
        end else begin
            prescale_cnt <= prescale_cnt + 1'b1;
        end
    end

    // Control FSM, counter and status register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= timer_pkg::st_idle;
            counter <= '0;
            en_q    <= 1'b0;
            status  <= '0;
        end else if (tamper_reset) begin
            // Same clear as rst, but synchronous
            state   <= timer_pkg::st_idle;
            counter <= '0;
            en_q    <= 1'b0;
            status  <= '0;
        end else begin
            en_q         <= timer_enable;
            status.count <= counter;            // One stage behind the counter

            case (state)
                timer_pkg::st_idle: begin
                    status.overflow <= 1'b0;
                    status.match    <= 1'b0;
                    status.active   <= 1'b0;
                    if (enable_rise) begin
                        counter       <= timer_load;
                        status.active <= 1'b1;
                        state         <= timer_pkg::st_running;
                    end else if (timer_reset) begin
                        counter <= '0;
                    end
                end

                timer_pkg::st_running: begin
                    if (!keep_running) begin
                        status.active <= 1'b0;
                        state         <= timer_pkg::st_idle;
                    end else if (tick) begin
                        // Compare wins over overflow
                        if (counter == compare_value) begin
                            status.match <= 1'b1;
                            state        <= timer_pkg::st_match;
                        end else if (counter == '1) begin
                            counter         <= '0;      // Wrap
                            status.overflow <= 1'b1;
                            state           <= timer_pkg::st_overflow;
                        end else begin
                            counter <= counter + 1'b1;
                        end
                    end
                end

                timer_pkg::st_overflow: begin
                    status.overflow <= 1'b0;
                    if (keep_running) begin
                        state <= timer_pkg::st_running;
                    end else begin
                        status.active <= 1'b0;
                        state         <= timer_pkg::st_idle;
                    end
                end

                timer_pkg::st_match: begin
                    status.match <= 1'b0;
                    if (keep_running) begin
                        counter <= counter + 1'b1;  // Step past the compare value
                        state   <= timer_pkg::st_running;
                    end else begin
                        status.active <= 1'b0;
                        state         <= timer_pkg::st_idle;
                    end
                end

                default: begin
                    state <= timer_pkg::st_idle;
                end
            endcase
        end
    end

endmodule

//--- hdl/timer_host.sv
//****************************************************************************
// Top level, timer core with its observation stream and trigger detector
// tamper_reset is a port so the trigger can be watched from outside
//****************************************************************************
`timescale 1ns/1ps

module timer_host (
    input  logic                     clk,
    input  logic                     rst,
    input  timer_pkg::timer_t        timer_load,
    input  timer_pkg::timer_t        compare_value,
    input  logic                     timer_enable,
    input  logic                     timer_reset,
    output timer_pkg::timer_status_t status,
    output logic                     tamper_reset
);

    timer_pkg::obs_byte_t obs_byte;
    logic                 advance;

    // Stream moves while the timer is requested or still running
    assign advance = timer_enable || status.active;

    byte_source i_byte_source (
        .clk           (clk),
        .rst           (rst),
        .advance       (advance),
        .count         (status.count),      // Registered count feeds the mix
        .compare_value (compare_value),
        .obs_byte      (obs_byte)
    );

    trigger_detector i_trigger_detector (
        .clk          (clk),
        .rst          (rst),
        .obs_byte     (obs_byte),
        .tamper_reset (tamper_reset)
    );

    timer_core i_timer_core (
        .clk           (clk),
        .rst           (rst),
        .tamper_reset  (tamper_reset),
        .timer_enable  (timer_enable),
        .timer_reset   (timer_reset),
        .timer_load    (timer_load),
        .compare_value (compare_value),
        .status        (status)
    );

endmodule

//--- test/tb_timer_host.sv
//****************************************************************************
// Testbench for timer_host, steps come from test/timer_patterns.txt
// A cycle model of stream, trigger and timer is checked on every clock
//****************************************************************************
`timescale 1ns/1ps

module tb_timer_host;

    logic                     clk;
    logic                     rst;
    logic                     timer_enable;
    logic                     timer_reset;
    timer_pkg::timer_t        timer_load;
    timer_pkg::timer_t        compare_value;
    timer_pkg::timer_status_t status;
    logic                     tamper_reset;

    // Reference model state, as it stands after the last rising edge
    timer_pkg::lfsr_t         m_lfsr;
    logic [2:0]               m_sel;
    int                       m_hits;
    logic                     m_tamper;
    timer_pkg::timer_state_e  m_state;
    timer_pkg::timer_t        m_counter;
    int                       m_phase;      // Clocks into the current tick
    logic                     m_en_q;
    timer_pkg::timer_status_t m_status;

    int match_seen;
    int ovf_seen;
    int tamper_seen;

    timer_host i_timer_host (
        .clk           (clk),
        .rst           (rst),
        .timer_load    (timer_load),
        .compare_value (compare_value),
        .timer_enable  (timer_enable),
        .timer_reset   (timer_reset),
        .status        (status),
        .tamper_reset  (tamper_reset)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    function automatic string status_text(input timer_pkg::timer_status_t s);
        return $sformatf("count=%h ovf=%b match=%b active=%b",
                         s.count, s.overflow, s.match, s.active);
    endfunction

    task automatic check_status(input string name, input timer_pkg::timer_status_t exp,
                                input timer_pkg::timer_status_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR at %0t ns: %s expected %s, got %s",
                               $time, name, status_text(exp), status_text(act)));
        end
    endtask

    task automatic check_tamper(input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR at %0t ns: tamper_reset expected %b, got %b",
                               $time, exp, act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            fail_run($sformatf("ERROR at %0t ns: %s expected %0d, got %0d",
                               $time, name, exp, act));
        end
    endtask

    function automatic timer_pkg::lfsr_t lfsr_next(input timer_pkg::lfsr_t r);
        return {r[30:0], r[31] ^ r[27] ^ r[15] ^ r[2]};
    endfunction

    // Slots 0..3 plain LFSR bytes, slots 4..7 masked by count then compare
    function automatic timer_pkg::obs_byte_t mix_byte(input timer_pkg::lfsr_t r,
                                                      input logic [2:0] slot,
                                                      input timer_pkg::timer_t cnt,
                                                      input timer_pkg::timer_t cmp);
        timer_pkg::obs_byte_t base;
        timer_pkg::obs_byte_t mask;
        timer_pkg::timer_t    mixer;
        base  = r[8*slot[1:0] +: 8];
        mixer = slot[1] ? cmp : cnt;
        mask  = slot[2] ? mixer[8*slot[0] +: 8] : 8'h00;
        return base ^ mask;
    endfunction

    task automatic model_reset;
        m_lfsr    = timer_pkg::lfsr_seed;
        m_sel     = 3'd0;
        m_hits    = 0;
        m_tamper  = 1'b0;
        m_state   = timer_pkg::st_idle;
        m_counter = '0;
        m_phase   = 0;
        m_en_q    = 1'b0;
        m_status  = '0;
    endtask

    // Next model state for the coming rising edge, from the inputs now driven
    task automatic model_step;
        timer_pkg::obs_byte_t     obs;
        logic                     tick;
        logic                     run_ok;
        logic                     fire;
        timer_pkg::timer_state_e  n_state;
        timer_pkg::timer_t        n_counter;
        timer_pkg::timer_status_t n_status;
        int                       n_phase;
        obs    = mix_byte(m_lfsr, m_sel, m_status.count, compare_value);
        tick   = m_status.active && (m_phase == timer_pkg::prescaler - 1);
        run_ok = timer_enable && !timer_reset;
        fire   = (obs == timer_pkg::trigger_byte) && (m_hits == timer_pkg::trigger_count - 1);

        if (timer_enable || m_status.active) begin
            m_lfsr = lfsr_next(m_lfsr);
            m_sel  = m_sel + 3'd1;
        end
        if (fire) begin
            m_hits = 0;
        end else if (obs == timer_pkg::trigger_byte) begin
            m_hits++;
        end

        n_phase = (m_tamper || !m_status.active) ? 0 : (m_phase + 1) % timer_pkg::prescaler;
        n_state   = m_state;
        n_counter = m_counter;
        n_status  = m_status;
        n_status.count = m_counter;
        if (m_tamper) begin
            n_state   = timer_pkg::st_idle;
            n_counter = '0;
            n_status  = '0;
        end else begin
            case (m_state)
                timer_pkg::st_idle: begin
                    if (timer_enable && !m_en_q) begin
                        n_counter       = timer_load;
                        n_status.active = 1'b1;
                        n_state         = timer_pkg::st_running;
                    end else if (timer_reset) begin
                        n_counter = '0;
                    end
                end
                timer_pkg::st_running: begin
                    if (!run_ok) begin
                        n_status.active = 1'b0;
                        n_state         = timer_pkg::st_idle;
                    end else if (tick && m_counter == compare_value) begin
                        n_status.match = 1'b1;
                        n_state        = timer_pkg::st_match;
                    end else if (tick && m_counter == '1) begin
                        n_counter         = '0;
                        n_status.overflow = 1'b1;
                        n_state           = timer_pkg::st_overflow;
                    end else if (tick) begin
                        n_counter = m_counter + 1'b1;
                    end
                end
                default: begin  // Flag states last one clock
                    n_status.match    = 1'b0;
                    n_status.overflow = 1'b0;
                    if (run_ok && m_state == timer_pkg::st_match) begin
                        n_counter = m_counter + 1'b1;
                    end
                    n_state = run_ok ? timer_pkg::st_running : timer_pkg::st_idle;
                    n_status.active = run_ok;
                end
            endcase
        end

        m_en_q    = m_tamper ? 1'b0 : timer_enable;
        m_tamper  = fire;
        m_state   = n_state;
        m_counter = n_counter;
        m_status  = n_status;
        m_phase   = n_phase;
    endtask

    // One clock, then compare DUT and model at the falling edge
    task automatic step_clock;
        model_step();
        @(negedge clk);
        check_status("status", m_status, status);
        check_tamper(m_tamper, tamper_reset);
        if (status.match) match_seen++;
        if (status.overflow) ovf_seen++;
        if (tamper_reset) tamper_seen++;
    endtask

    task automatic wait_active(input logic want, input int limit);
        int n;
        n = 0;
        while (status.active !== want && n < limit) begin
            step_clock();
            n++;
        end
        if (status.active !== want) begin
            fail_run($sformatf("Timer active did not reach %b within %0d cycles", want, limit));
        end
    endtask

    // Drop enable, then give a fresh rising edge with new load and compare
    task automatic restart_timer(input timer_pkg::timer_t load, input timer_pkg::timer_t cmp);
        timer_enable  = 1'b0;
        timer_load    = load;
        compare_value = cmp;
        step_clock();
        wait_active(1'b0, 8);
        timer_enable = 1'b1;
        wait_active(1'b1, 8);
    endtask

    // Steer compare_value so that slots 6 and 7 carry the trigger byte
    task automatic wait_tamper(input int limit);
        int   n;
        logic fired;
        n     = 0;
        fired = 1'b0;
        while (!fired && n < limit) begin
            if (m_sel == 3'd6) begin
                compare_value[7:0] = m_lfsr[23:16] ^ timer_pkg::trigger_byte;
            end else if (m_sel == 3'd7) begin
                compare_value[15:8] = m_lfsr[31:24] ^ timer_pkg::trigger_byte;
            end
            step_clock();
            fired = tamper_reset;
            n++;
        end
        if (!fired) begin
            fail_run($sformatf("tamper_reset did not pulse within %0d cycles", limit));
        end
    endtask

    task automatic idle_gap;
        int gap;
        gap = $urandom % 4;
        repeat (gap) step_clock();
    endtask

    task automatic run_step(input string op, input timer_pkg::timer_t load,
                            input timer_pkg::timer_t cmp, input int cycles,
                            input timer_pkg::timer_t exp_count, input int exp_match,
                            input int exp_ovf, input int exp_tamper);
        timer_pkg::timer_status_t expect_st;
        expect_st       = '0;
        expect_st.count = exp_count;
        if (op == "load_run" || op == "clear" || op == "trigger") begin
            idle_gap();
        end
        match_seen  = 0;
        ovf_seen    = 0;
        tamper_seen = 0;

        if (op == "load_run") begin
            restart_timer(load, cmp);
            repeat (timer_pkg::prescaler * cycles + 1) step_clock();
            expect_st.active = 1'b1;
        end else if (op == "hold") begin
            repeat (timer_pkg::prescaler * cycles) step_clock();
            expect_st.active = 1'b1;
        end else if (op == "disable") begin
            timer_enable = 1'b0;
            wait_active(1'b0, 8);
        end else if (op == "clear") begin
            timer_reset = 1'b1;
            step_clock();
            timer_reset = 1'b0;
            step_clock();       // Cleared counter reaches status.count
        end else if (op == "trigger") begin
            restart_timer(load, cmp);
            wait_tamper(cycles);
            step_clock();       // Status cleared one clock after the pulse
        end else begin
            fail_run($sformatf("Unknown opcode %s in pattern file", op));
        end

        check_status("status", expect_st, status);
        check_count("match pulses", exp_match, match_seen);
        check_count("overflow pulses", exp_ovf, ovf_seen);
        check_count("tamper pulses", exp_tamper, tamper_seen);
    endtask

    initial begin : watchdog
        int n;
        for (n = 0; n < 100000; n++) @(posedge clk);
        fail_run($sformatf("Run did not finish within %0d clock cycles", n));
    end

    initial begin : stimulus
        int                fd;
        int                code;
        int                nread;
        int                steps;
        string             line;
        string             op;
        timer_pkg::timer_t p_load;
        timer_pkg::timer_t p_cmp;
        timer_pkg::timer_t p_exp;
        int                p_cycles;
        int                p_match;
        int                p_ovf;
        int                p_tamper;
        rst           = 1'b1;
        timer_enable  = 1'b0;
        timer_reset   = 1'b0;
        timer_load    = '0;
        compare_value = '0;
        steps         = 0;
        code          = $urandom(32'h12c5);     // Seeds the idle gap draws
        model_reset();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        check_status("status", '0, status);
        check_tamper(1'b0, tamper_reset);

        fd = $fopen("test/timer_patterns.txt", "r");
        if (fd == 0) begin
            fail_run("Could not open test/timer_patterns.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            code = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#") begin
                nread = $sscanf(line, "%s %h %h %d %h %d %d %d", op, p_load, p_cmp,
                                p_cycles, p_exp, p_match, p_ovf, p_tamper);
                if (nread != 8) begin
                    fail_run($sformatf("Malformed pattern line: %s", line));
                end
                run_step(op, p_load, p_cmp, p_cycles, p_exp, p_match, p_ovf, p_tamper);
                steps++;
            end
        end
        $fclose(fd);

        if (steps == 0) begin
            fail_run("Pattern file held no steps");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

//--- test/timer_patterns.txt
# op load compare cycles exp_count matches overflows tamper (load, compare, exp_count in hex)
# cycles is ticks for load_run and hold, a cycle limit for trigger, unused otherwise
load_run 0040 7000 0 0040 0 0 0
hold 0000 0000 5 0045 0 0 0
load_run 0010 7000 6 0016 0 0 0
hold 0000 0000 10 0020 0 0 0
disable 0000 0000 0 0020 0 0 0
clear 0000 0000 0 0000 0 0 0
# Compare match, counting resumes past the compare value
load_run 0100 0104 8 0108 1 0 0
hold 0000 0000 4 010c 0 0 0
disable 0000 0000 0 010c 0 0 0
clear 0000 0000 0 0000 0 0 0
# Overflow from fffe wraps to zero
load_run fffe 8000 4 0002 0 1 0
hold 0000 0000 3 0005 0 0 0
disable 0000 0000 0 0005 0 0 0
clear 0000 0000 0 0000 0 0 0
# Match lands inside a hold step
load_run 0200 0203 3 0203 0 0 0
hold 0000 0000 2 0205 1 0 0
# Trigger bytes steered into the stream until the clear fires
trigger 0300 7000 300 0000 0 0 1
load_run 0050 7000 4 0054 0 0 0
disable 0000 0000 0 0054 0 0 0
clear 0000 0000 0 0000 0 0 0
trigger 0000 7000 300 0000 0 0 1
load_run 0001 7000 2 0003 0 0 0
hold 0000 0000 1 0004 0 0 0
disable 0000 0000 0 0004 0 0 0
clear 0000 0000 0 0000 0 0 0

//--- all.f
hdl/timer_pkg.sv
hdl/byte_source.sv
hdl/trigger_detector.sv
hdl/timer_core.sv
hdl/timer_host.sv
test/tb_timer_host.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the timer_host testbench with Verilator and runs it from the project root.
# The run passes only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir "$BUILD_LOG" "$SIM_LOG"

verilator --binary -Wno-fatal --timescale 1ns/1ps --top-module tb_timer_host \
    -f all.f -o sim_timer_host > "$BUILD_LOG" 2>&1 \
    && ./obj_dir/sim_timer_host > "$SIM_LOG" 2>&1 \
    || { echo "Build or simulation ended with an error"; cat "$BUILD_LOG" "$SIM_LOG" 2>/dev/null; }

grep -qx "TESTBENCH PASSED" "$SIM_LOG" 2>/dev/null \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see $SIM_LOG"; exit 1; }
